/* src/trs_link_defs.svh */
`ifndef TRS_LINK_DEFS_SVH
`define TRS_LINK_DEFS_SVH

// identification byte returned by get_cookie
`define LINK_COOKIE 8'hAF

// version byte is {major, minor}
`define LINK_VER_MAJOR 3'd0
`define LINK_VER_MINOR 5'd3

// 32 KiB shared memory
`define LINK_ADDR_W 15

// longest command (bram_poke) carries this many bytes
`define LINK_MAX_PARAMS 3

`endif

/* src/trs_link_pkg.sv */
package trs_link_pkg;

  `include "trs_link_defs.svh"

  // opcode as sent on the wire
  typedef enum logic [7:0] {
    cmd_get_cookie  = 8'd0,
    cmd_bram_poke   = 8'd1,
    cmd_bram_peek   = 8'd2,
    cmd_get_version = 8'd15
  } link_cmd_e;

  // slot 0 is the first byte after the opcode
  typedef logic [`LINK_MAX_PARAMS-1:0][7:0] link_params_t;

  typedef struct packed {
    link_cmd_e    op;
    link_params_t params;
  } link_cmd_t;

  typedef struct packed {
    logic       load;  // copy data into the tx shifter
    logic [7:0] data;
  } link_reply_t;

  typedef struct packed {
    logic sck;
    logic mosi;
    logic cs_n;
  } spi_pins_t;

endpackage

/* src/spi_byte_link.sv */
module spi_byte_link import trs_link_pkg::*; (
  input  logic        clk,
  input  logic        arst_n,
  input  spi_pins_t   pins,
  input  link_reply_t reply,
  output logic [7:0]  rx_byte,
  output logic        rx_valid,
  output logic        frame_start,
  output logic        miso
);

  // pins as seen while the link sits idle
  localparam spi_pins_t pins_idle = '{sck: 1'b0, mosi: 1'b0, cs_n: 1'b1};

  spi_pins_t  meta_q;     // first sync stage
  spi_pins_t  sync_q;     // safe to use
  logic       sck_last_q; // for edge detect
  logic       cs_n_last_q;
  logic [2:0] bit_cnt_q;
  logic [7:0] rx_shift_q;
  logic [7:0] tx_shift_q;
  logic       rx_valid_q;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_active;

  // two-flop synchronizers plus one stage of history
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      meta_q      <= pins_idle;
      sync_q      <= pins_idle;
      sck_last_q  <= 1'b0;
      cs_n_last_q <= 1'b1;
    end else begin
      meta_q      <= pins;
      sync_q      <= meta_q;
      sck_last_q  <= sync_q.sck;
      cs_n_last_q <= sync_q.cs_n;
    end
  end

  assign sck_rise    = sync_q.sck & ~sck_last_q;
  assign sck_fall    = ~sync_q.sck & sck_last_q;
  assign cs_active   = ~sync_q.cs_n;
  assign frame_start = cs_n_last_q & ~sync_q.cs_n; // cs falling

  // receive side, mode 0 samples on rising sck
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt_q  <= 3'd0;
      rx_valid_q <= 1'b0;
    end else begin
      rx_valid_q <= cs_active && sck_rise && (bit_cnt_q == 3'd7); // eighth bit
      if (!cs_active) begin
        bit_cnt_q <= 3'd0; // resync on every frame
      end else if (sck_rise) begin
        bit_cnt_q <= bit_cnt_q + 3'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cs_active && sck_rise) begin
      rx_shift_q <= {rx_shift_q[6:0], sync_q.mosi}; // msb first
    end
  end

  assign rx_byte  = rx_shift_q; // complete while rx_valid is high
  assign rx_valid = rx_valid_q;

  // transmit side, next bit goes out on falling sck
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tx_shift_q <= 8'h00;
    end else if (frame_start) begin
      tx_shift_q <= 8'h00; // no stale reply into a new frame
    end else if (reply.load) begin
      tx_shift_q <= reply.data;
    end else if (cs_active && sck_fall) begin
      tx_shift_q <= {tx_shift_q[6:0], 1'b0};
    end
  end

  assign miso = cs_active & tx_shift_q[7]; // low between frames

  // a byte strobe only rises inside a frame
  rx_valid_in_frame: assert property (
    @(posedge clk) disable iff (!arst_n) $rose(rx_valid) |-> cs_active
  ) else $error("rx_valid raised while cs was inactive");

endmodule

/* src/cmd_parser.sv */
`include "trs_link_defs.svh"

module cmd_parser import trs_link_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  logic [7:0] rx_byte,
  input  logic       rx_valid,
  input  logic       frame_start,
  output link_cmd_t  cmd,
  output logic       exec
);

  localparam int cnt_w = $clog2(`LINK_MAX_PARAMS + 1);

  typedef enum logic [1:0] {
    st_idle,   // waiting for an opcode
    st_params, // collecting parameter bytes
    st_done    // reply pending, rest of frame is dummy bytes
  } state_e;

  state_e           state_q;
  logic [cnt_w-1:0] param_left_q; // bytes still to come
  logic [cnt_w-1:0] param_idx_q;  // next slot
  logic             exec_q;
  link_cmd_t        cmd_q;

  // parameter bytes per opcode
  function automatic logic [cnt_w-1:0] param_count(input link_cmd_e op);
    case (op)
      cmd_bram_poke: param_count = cnt_w'(`LINK_MAX_PARAMS); // addr lo, addr hi, data
      cmd_bram_peek: param_count = cnt_w'(2);                // addr lo, addr hi
      default:       param_count = '0;
    endcase
  endfunction

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q      <= st_idle;
      param_left_q <= '0;
      param_idx_q  <= '0;
      exec_q       <= 1'b0;
    end else begin
      exec_q <= 1'b0; // strobe
      if (frame_start) begin
        state_q <= st_idle;
      end else if (rx_valid) begin
        case (state_q)
          st_idle: begin
            case (rx_byte)
              cmd_get_cookie, cmd_get_version: begin
                exec_q  <= 1'b1; // no parameters, fire now
                state_q <= st_done;
              end
              cmd_bram_poke, cmd_bram_peek: begin
                param_left_q <= param_count(link_cmd_e'(rx_byte));
                param_idx_q  <= '0;
                state_q      <= st_params;
              end
              default: state_q <= st_idle; // unknown opcode dropped
            endcase
          end
          st_params: begin
            param_idx_q <= param_idx_q + 1'b1;
            if (param_left_q == cnt_w'(1)) begin
              exec_q <= 1'b1;
              // a poke has no reply, so the next byte may be a new opcode
              state_q <= (cmd_q.op == cmd_bram_poke) ? st_idle : st_done;
            end else begin
              param_left_q <= param_left_q - 1'b1;
            end
          end
          default: ; // st_done ignores dummy bytes until cs drops
        endcase
      end
    end
  end

  // command record
  always_ff @(posedge clk) begin
    if (rx_valid && state_q == st_idle) begin
      cmd_q.op <= link_cmd_e'(rx_byte);
    end
    if (rx_valid && state_q == st_params) begin
      cmd_q.params[param_idx_q] <= rx_byte;
    end
  end

  assign cmd  = cmd_q;
  assign exec = exec_q;

  // count and index must stay in step across the whole command
  param_slot_in_range: assert property (
    @(posedge clk) disable iff (!arst_n)
    (state_q == st_params && rx_valid) |-> (param_idx_q < `LINK_MAX_PARAMS)
  ) else $error("parameter index ran past the last slot");

endmodule

/* src/cmd_executor.sv */
`include "trs_link_defs.svh"

module cmd_executor import trs_link_pkg::*; (
  input  logic        clk,
  input  logic        arst_n,
  input  link_cmd_t   cmd,
  input  logic        exec,
  output link_reply_t reply
);

  localparam int depth = 2 ** `LINK_ADDR_W;

  logic [7:0]              mem [0:depth-1]; // shared memory
  logic [`LINK_ADDR_W-1:0] addr;
  logic                    mem_we;
  logic                    mem_re;
  logic                    ident;     // cookie or version
  logic [7:0]              rd_data_q; // memory output
  logic                    rd_valid_q;
  logic                    load_q;
  logic [7:0]              data_q;

  // top bit of the high byte is dropped
  assign addr   = {cmd.params[1][`LINK_ADDR_W-9:0], cmd.params[0]};
  assign mem_we = exec && (cmd.op == cmd_bram_poke);
  assign mem_re = exec && (cmd.op == cmd_bram_peek);
  assign ident  = exec && (cmd.op == cmd_get_cookie || cmd.op == cmd_get_version);

  // single port, write lands the cycle after exec
  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[addr] <= cmd.params[2];
    end
    if (mem_re) begin
      rd_data_q <= mem[addr]; // one cycle read latency
    end
  end

  // peek valid follows the read data
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_valid_q <= 1'b0;
      load_q     <= 1'b0;
    end else begin
      rd_valid_q <= mem_re;
      load_q     <= rd_valid_q || ident; // peek +2, ident +1
    end
  end

  // reply byte, memory has priority since it was issued first
  always_ff @(posedge clk) begin
    if (rd_valid_q) begin
      data_q <= rd_data_q;
    end else if (exec && cmd.op == cmd_get_cookie) begin
      data_q <= `LINK_COOKIE;
    end else if (exec && cmd.op == cmd_get_version) begin
      data_q <= {`LINK_VER_MAJOR, `LINK_VER_MINOR};
    end
  end

  assign reply = '{load: load_q, data: data_q};

  // parser holds off after a reply command, so a poke can't meet a load
  no_write_during_load: assert property (
    @(posedge clk) disable iff (!arst_n) !(mem_we && load_q)
  ) else $error("memory write collided with a reply load");

endmodule

/* src/trs_link_top.sv */
module trs_link_top import trs_link_pkg::*; (
  input  logic clk,
  input  logic arst_n,
  input  logic sck,
  input  logic mosi,
  input  logic cs_n,
  output logic miso
);

  spi_pins_t   pins;
  logic [7:0]  rx_byte;
  logic        rx_valid;
  logic        frame_start;
  link_cmd_t   cmd;
  logic        exec;
  link_reply_t reply;

  assign pins = '{sck: sck, mosi: mosi, cs_n: cs_n}; // raw, async to clk

  // pins to bytes and back
  spi_byte_link u_link (
    .clk         (clk),
    .arst_n      (arst_n),
    .pins        (pins),
    .reply       (reply),
    .rx_byte     (rx_byte),
    .rx_valid    (rx_valid),
    .frame_start (frame_start),
    .miso        (miso)
  );

  cmd_parser u_parser (
    .clk         (clk),
    .arst_n      (arst_n),
    .rx_byte     (rx_byte),
    .rx_valid    (rx_valid),
    .frame_start (frame_start),
    .cmd         (cmd),
    .exec        (exec)
  );

  // memory and reply select
  cmd_executor u_exec (
    .clk    (clk),
    .arst_n (arst_n),
    .cmd    (cmd),
    .exec   (exec),
    .reply  (reply)
  );

endmodule

/* testbench/tb_trs_link.sv */
module tb_trs_link;
  timeunit 1ns;
  timeprecision 1ps;

  // short sck phases, a command's trailing fall lands no later than the reply load
  localparam int sck_half  = 3;
  localparam int reply_gap = 16;  // clk between command and dummy byte
  localparam int cs_settle = 4;   // pin to sync is 2 to 3 clk
  localparam int frame_gap = 10;  // idle clk between frames
  localparam int max_lines = 256; // bound on pattern file reads

  logic clk;
  logic arst_n;
  logic sck;
  logic mosi;
  logic cs_n;
  logic miso;

  trs_link_top DUT (
    .clk    (clk),
    .arst_n (arst_n),
    .sck    (sck),
    .mosi   (mosi),
    .cs_n   (cs_n),
    .miso   (miso)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk; // 8 ns
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] want);
    if (got !== want) begin
      abort_run($sformatf("CHECK FAILED: %s got 0x%02h expected 0x%02h", name, got, want));
    end
  endtask

  // every drive happens on a falling clk edge
  task automatic wait_clks(input int n);
    int i;
    for (i = 0; i < n; i++) begin
      @(negedge clk);
    end
  endtask

  // mode 0, msb first, returns what miso carried
  task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
    int i;
    for (i = 7; i >= 0; i--) begin
      mosi = tx[i]; // sck low here
      wait_clks(sck_half);
      rx[i] = miso; // just before the rising edge
      sck = 1'b1;
      wait_clks(sck_half);
      sck = 1'b0;   // slave shifts its next bit out
    end
  endtask

  // one frame: opcode, parameters, optional dummy byte for the reply
  task automatic run_command(input logic [7:0] op, input int n_params,
                             input logic [2:0][7:0] params, input logic has_reply,
                             output logic [7:0] reply);
    logic [7:0] ignored;
    int i;
    reply = 8'h00;
    cs_n = 1'b0;
    wait_clks(cs_settle); // frame_start clears the tx shifter
    spi_byte(op, ignored);
    for (i = 0; i < n_params; i++) begin
      spi_byte(params[i], ignored);
    end
    if (has_reply) begin
      wait_clks(reply_gap);   // executor loads the reply meanwhile
      spi_byte(8'h00, reply); // dummy byte clocks it out
    end
    wait_clks(sck_half);
    cs_n = 1'b1;
  endtask

  // miso has to sit at 0 for the whole gap
  task automatic idle_gap();
    int i;
    wait_clks(cs_settle);
    for (i = cs_settle; i < frame_gap; i++) begin
      check_value("miso while cs inactive", {7'd0, miso}, 8'h00);
      @(negedge clk);
    end
  endtask

  initial begin
    int fd;
    int line_no;
    int cmd_cnt;
    string line;
    logic [7:0] op;
    logic [7:0] cnt;
    logic [7:0] p0;
    logic [7:0] p1;
    logic [7:0] p2;
    logic [7:0] has;
    logic [7:0] want;
    logic [7:0] got;
    arst_n = 1'b0;
    sck    = 1'b0;
    mosi   = 1'b0;
    cs_n   = 1'b1;
    wait_clks(2); // reset for two cycles
    arst_n = 1'b1;
    wait_clks(frame_gap);
    check_value("miso after reset", {7'd0, miso}, 8'h00);
    fd = $fopen("testbench/link_patterns.txt", "r");
    if (fd == 0) begin
      abort_run("could not open testbench/link_patterns.txt for reading");
    end
    line_no = 0;
    cmd_cnt = 0;
    while (!$feof(fd) && line_no < max_lines) begin
      line = "";
      void'($fgets(line, fd));
      line_no++;
      if (line.len() == 0 || line[0] == "#" || line[0] == "\n") begin
        continue; // column header or blank
      end
      if ($sscanf(line, "%h %h %h %h %h %h %h", op, cnt, p0, p1, p2, has, want) != 7) begin
        abort_run($sformatf("pattern line %0d does not hold seven hex fields", line_no));
      end
      if (cnt > 8'd3) begin
        abort_run($sformatf("pattern line %0d asks for more than three parameters", line_no));
      end
      run_command(op, int'(cnt), {p2, p1, p0}, has[0], got);
      if (has[0]) begin
        check_value($sformatf("miso reply, line %0d op 0x%02h", line_no, op), got, want);
      end
      idle_gap(); // also covers behavior between frames
      cmd_cnt++;
    end
    $fclose(fd);
    // cookie left unread in the shifter, miso still has to stay low
    run_command(8'h00, 0, '0, 1'b0, got);
    idle_gap();
    if (cmd_cnt == 0) begin
      abort_run("pattern file held no commands");
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

/* src.f */
+incdir+src
src/trs_link_pkg.sv
src/spi_byte_link.sv
src/cmd_parser.sv
src/cmd_executor.sv
src/trs_link_top.sv
testbench/tb_trs_link.sv

/* run.sh */
#!/bin/sh
# build with verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_trs_link -f src.f -o tb_trs_link > build.log 2>&1 \
  && ./obj_dir/tb_trs_link > sim.log 2>&1 \
  || echo "build or simulation exited with an error, see build.log and sim.log"
grep -qx "TESTS PASSED" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

/* testbench/link_patterns.txt */
# opcode nparams p0 p1 p2 reply_flag expected_reply, all hex
# p0 p1 are address low and high, p2 is poke data, unused fields are 00
00 0 00 00 00 1 AF
0F 0 00 00 00 1 03
01 3 00 00 5A 0 00
02 2 00 00 00 1 5A
01 3 FF 7F C3 0 00
02 2 FF 7F 00 1 C3
01 3 34 12 A5 0 00
02 2 34 12 00 1 A5
01 3 01 00 E7 0 00
02 2 00 00 00 1 5A
02 2 01 00 00 1 E7
01 3 10 80 3C 0 00
02 2 10 00 00 1 3C
01 3 FF FF 81 0 00
02 2 FF 7F 00 1 81
2A 0 00 00 00 0 00
00 0 00 00 00 1 AF
0F 0 00 00 00 1 03
01 3 00 00 96 0 00
02 2 00 00 00 1 96
02 2 34 12 00 1 A5
